// ==== build.f ====
+incdir+hdl
hdl/conv_pkg.sv
hdl/layer_sequencer.sv
hdl/operand_fetch.sv
hdl/mac_array.sv
hdl/result_writer.sv
hdl/conv_tile_engine.sv
bench/tb_mem_model.sv
bench/tb_conv_tile_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_tile_engine
RTL_TOP   ?= conv_tile_engine
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_conv_tile_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module tb_conv_tile_engine
  import conv_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int RUNS           = 2;
  localparam int CYCLES_PER_RUN = 2000;
  localparam int PIXELS         = 150;

  logic       clk, reset, start, hold;
  logic       busy, done;
  logic       feat_req, wgt_req, wgt_bias;
  layer_idx_t req_layer, out_layer;
  chnl_idx_t  req_chnl, req_k, out_chnl;
  coord_t     req_row, req_col, out_row, out_col;
  feat_t [`SA_N*`SA_N-1:0] feat_data;
  wgt_t       wgt_data;
  logic       out_valid;
  acc_t       out_data;

  // Expected pixels as {layer, chnl, row, col, data}
  logic [35:0] exp_q[$];
  logic [35:0] exp_head = '0;
  int          exp_left = 0;
  int          out_count = 0;
  int          total_out = 0;
  int          done_cnt = 0;
  int          errors = 0;
  logic [31:0] lcg_state;
  int          cur_h, cur_w;

  conv_tile_engine DUT (
    .clk, .reset, .start, .hold, .busy, .done,
    .feat_req, .wgt_req, .wgt_bias, .req_layer, .req_chnl, .req_k,
    .req_row, .req_col, .feat_data, .wgt_data,
    .out_valid, .out_layer, .out_chnl, .out_row, .out_col, .out_data
  );

  tb_mem_model u_mem (
    .clk, .feat_req, .wgt_req, .wgt_bias, .req_layer, .req_chnl, .req_k,
    .req_row, .req_col, .feat_data, .wgt_data
  );

  function automatic void layer_geometry(input int l, output int h, output int w,
                                         output int ic, output int oc);
    case (l)
      0: begin
        h  = `L0_H;
        w  = `L0_W;
        ic = `L0_IN_C;
        oc = `L0_OUT_C;
      end
      1: begin
        h  = `L1_H;
        w  = `L1_W;
        ic = `L1_IN_C;
        oc = `L1_OUT_C;
      end
      default: begin
        h  = `L2_H;
        w  = `L2_W;
        ic = `L2_IN_C;
        oc = `L2_OUT_C;
      end
    endcase
  endfunction

  // Hash rules of the memory contents with the sign taken from the low byte
  function automatic int feat_ref(int l, int k, int r, int c);
    logic [31:0] v;
    v = l * 37 + k * 11 + r * 5 + c * 3 + 1;
    return int'($signed(v[7:0]));
  endfunction

  function automatic int wgt_ref(int l, int ch, int k);
    logic [31:0] v;
    v = l * 13 + ch * 7 + k * 3 + 2;
    return int'($signed(v[7:0]));
  endfunction

  function automatic int bias_ref(int ch);
    logic [31:0] v;
    v = ch * 9 - 20;
    return int'($signed(v[7:0]));
  endfunction

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Walk layers, channels, tile rows, tile columns, then pixels in the tile
  task automatic build_expected();
    int l, c, tr, tc, i, j, k, h, w, ic, oc, v;
    exp_q.delete();
    for (l = 0; l < `NUM_LAYERS; l++) begin
      layer_geometry(l, h, w, ic, oc);
      for (c = 0; c < oc; c++) begin
        for (tr = 0; tr < h; tr += `SA_N) begin
          for (tc = 0; tc < w; tc += `SA_N) begin
            for (i = 0; i < `SA_N; i++) begin
              for (j = 0; j < `SA_N; j++) begin
                if (tr + i < h && tc + j < w) begin
                  v = bias_ref(c);
                  for (k = 0; k < ic; k++) begin
                    v += feat_ref(l, k, tr + i, tc + j) * wgt_ref(l, c, k);
                  end
                  exp_q.push_back({2'(l), 2'(c), 4'(tr + i), 4'(tc + j), 24'(v)});
                end
              end
            end
          end
        end
      end
    end
    exp_left = exp_q.size();
    exp_head = exp_q[0];
  endtask

  // One full pass over the layer list with an optional start while busy
  task automatic run_network(input logic poke_busy);
    build_expected();
    out_count = 0;
    done_cnt  = 0;
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    if (poke_busy) begin
      repeat (40) @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
    end
    do @(negedge clk); while (!done);
    repeat (2) @(negedge clk);
    assert (out_count == PIXELS) else begin
      errors++;
      $display("FAILED %0t: %0d pixels seen, expected %0d", $time, out_count, PIXELS);
    end
    assert (done_cnt == 1) else begin
      errors++;
      $display("FAILED %0t: done pulsed %0d times in one run, expected 1", $time, done_cnt);
    end
    total_out += out_count;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Random hold level that changes just after each rising edge
  initial begin
    hold      = 1'b0;
    lcg_state = 32'hab75_441a;
    forever begin
      @(posedge clk);
      #1;
      lcg_state = lcg_next(lcg_state);
      hold      = (lcg_state[31:30] == 2'b00);
    end
  end

  // Pop each emitted pixel after the assertions sampled the head
  always @(posedge clk) begin
    if (out_valid) begin
      out_count = out_count + 1;
      if (exp_q.size() != 0) void'(exp_q.pop_front());
    end
    if (done) done_cnt = done_cnt + 1;
    exp_left = exp_q.size();
    exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  // Map size of the layer on the output port
  always_comb begin
    int ic, oc;
    layer_geometry(int'(out_layer), cur_h, cur_w, ic, oc);
  end

  a_reset_quiet: assert property (@(posedge clk)
    reset |-> !busy && !done && !out_valid && !feat_req && !wgt_req)
    else begin
      errors++;
      $display("Outputs active during reset at %0t", $time);
    end

  a_idle_stays: assert property (@(posedge clk) disable iff (reset)
    !busy && !start |=> !busy)
    else begin
      errors++;
      $display("Engine left idle without start at %0t", $time);
    end

  a_start_taken: assert property (@(posedge clk) disable iff (reset)
    !busy && start |=> busy)
    else begin
      errors++;
      $display("Start pulse not taken at %0t", $time);
    end

  a_order: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> exp_left != 0 &&
      {out_layer, out_chnl, out_row, out_col} == exp_head[35:24])
    else begin
      errors++;
      $display("FAILED %0t: pixel l%0d c%0d (%0d,%0d), expected key %h", $time,
               $sampled(out_layer), $sampled(out_chnl), $sampled(out_row),
               $sampled(out_col), $sampled(exp_head[35:24]));
    end

  a_data: assert property (@(posedge clk) disable iff (reset)
    out_valid && exp_left != 0 |-> out_data == exp_head[23:0])
    else begin
      errors++;
      $display("FAILED %0t: out_data %0d, expected %0d", $time,
               $sampled(out_data), $signed($sampled(exp_head[23:0])));
    end

  // Edge tiles must not spill past the map
  a_bounds: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_row < cur_h && out_col < cur_w)
    else begin
      errors++;
      $display("FAILED %0t: pixel (%0d,%0d) outside layer %0d", $time,
               $sampled(out_row), $sampled(out_col), $sampled(out_layer));
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    hold |-> !out_valid && !feat_req && !wgt_req)
    else begin
      errors++;
      $display("Activity while hold was high at %0t", $time);
    end

  a_done_last: assert property (@(posedge clk) disable iff (reset)
    done |-> exp_left == 0 && done_cnt == 0 && !out_valid)
    else begin
      errors++;
      $display("done early or repeated at %0t", $time);
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else begin
      errors++;
      $display("done longer than one cycle at %0t", $time);
    end

  initial begin
    reset = 1'b1;
    start = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    assert (!busy && !done && !out_valid) else begin
      errors++;
      $display("Outputs not low after reset at %0t", $time);
    end
    run_network(1'b1);
    // Second pass must repeat the same sequence
    run_network(1'b0);
    $display("Pixels checked %0d, errors %0d", total_out, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog over both runs
  initial begin
    #(RUNS * CYCLES_PER_RUN * CLK_PERIOD);
    $display("Timeout after %0d cycles, pixels %0d, errors %0d",
             RUNS * CYCLES_PER_RUN, total_out + out_count, errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module tb_mem_model
  import conv_pkg::*;
(
  input  logic       clk
  ,input  logic      feat_req
  ,input  logic      wgt_req
  ,input  logic      wgt_bias
  ,input  layer_idx_t req_layer
  ,input  chnl_idx_t req_chnl
  ,input  chnl_idx_t req_k
  ,input  coord_t    req_row
  ,input  coord_t    req_col
  ,output feat_t [`SA_N*`SA_N-1:0] feat_data
  ,output wgt_t      wgt_data
);

  // Feature plane contents, low byte of the hash
  function automatic feat_t feature(int l, int k, int r, int c);
    logic [31:0] v;
    v = l * 37 + k * 11 + r * 5 + c * 3 + 1;
    return feat_t'(v[7:0]);
  endfunction

  // Weight table, one value per layer, output channel and step
  function automatic wgt_t weight(int l, int ch, int k);
    logic [31:0] v;
    v = l * 13 + ch * 7 + k * 3 + 2;
    return wgt_t'(v[7:0]);
  endfunction

  function automatic wgt_t bias(int ch);
    logic [31:0] v;
    v = ch * 9 - 20;
    return wgt_t'(v[7:0]);
  endfunction

  initial begin
    feat_data = '0;
    wgt_data  = '0;
  end

  // One cycle read latency, data holds until the next request
  always @(posedge clk) begin
    if (feat_req) begin
      for (int i = 0; i < `SA_N; i++) begin
        for (int j = 0; j < `SA_N; j++) begin
          // Lane i*SA_N+j is tile pixel row i, column j
          feat_data[i*`SA_N+j] <= feature(int'(req_layer), int'(req_k),
                                          int'(req_row) + i, int'(req_col) + j);
        end
      end
    end
    if (wgt_req) begin
      wgt_data <= wgt_bias ? bias(int'(req_chnl))
                           : weight(int'(req_layer), int'(req_chnl), int'(req_k));
    end
  end

endmodule

`default_nettype wire

// ==== hdl/conv_tile_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_tile_engine
  import conv_pkg::*;
(
  input  logic      clk
  ,input  logic     reset
  ,input  logic     start
  ,input  logic     hold
  ,output logic     busy
  ,output logic     done
  // Feature and weight memory requests
  ,output logic     feat_req
  ,output logic     wgt_req
  ,output logic     wgt_bias
  ,output layer_idx_t req_layer
  ,output chnl_idx_t req_chnl
  ,output chnl_idx_t req_k
  ,output coord_t   req_row
  ,output coord_t   req_col
  // Read data, one cycle after the request
  ,input  feat_t [`SA_N*`SA_N-1:0] feat_data
  ,input  wgt_t     wgt_data
  // Result pixels
  ,output logic     out_valid
  ,output layer_idx_t out_layer
  ,output chnl_idx_t out_chnl
  ,output coord_t   out_row
  ,output coord_t   out_col
  ,output acc_t     out_data
);

  // Sequencer to datapath
  logic       clear, bias_req, run_go, drain_go;
  layer_idx_t layer;
  chnl_idx_t  chnl, in_ch;
  coord_t     tile_row, tile_col;
  logic [`SA_N*`SA_N-1:0] pe_mask;

  // Datapath back to the sequencer
  logic bias_valid, step_valid, fetch_idle, drain_done;

  acc_t [`SA_N*`SA_N-1:0] acc;

  layer_sequencer u_seq (
    .clk, .reset, .start, .hold, .fetch_idle, .drain_done,
    .clear, .bias_req, .run_go, .drain_go, .busy, .done,
    .layer, .chnl, .tile_row, .tile_col, .in_ch, .pe_mask
  );

  operand_fetch u_fetch (
    .clk, .reset, .run_go, .bias_req, .hold,
    .layer, .chnl, .in_ch, .tile_row, .tile_col,
    .feat_req, .wgt_req, .wgt_bias, .req_layer, .req_chnl, .req_k,
    .req_row, .req_col, .bias_valid, .step_valid, .fetch_idle
  );

  mac_array u_mac (
    .clk, .reset, .clear, .bias_valid, .step_valid,
    .feat_data, .wgt_data, .acc
  );

  result_writer u_wr (
    .clk, .reset, .drain_go, .hold, .pe_mask, .acc,
    .layer, .chnl, .tile_row, .tile_col,
    .out_valid, .out_layer, .out_chnl, .out_row, .out_col, .out_data,
    .drain_done
  );

endmodule

`default_nettype wire

// ==== hdl/result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module result_writer
  import conv_pkg::*;
(
  input  logic      clk
  ,input  logic     reset
  ,input  logic     drain_go
  ,input  logic     hold
  ,input  logic [`SA_N*`SA_N-1:0] pe_mask
  ,input  acc_t [`SA_N*`SA_N-1:0] acc
  ,input  layer_idx_t layer
  ,input  chnl_idx_t chnl
  ,input  coord_t   tile_row
  ,input  coord_t   tile_col
  ,output logic     out_valid
  ,output layer_idx_t out_layer
  ,output chnl_idx_t out_chnl
  ,output coord_t   out_row
  ,output coord_t   out_col
  ,output acc_t     out_data
  ,output logic     drain_done
);

  localparam int LANES = `SA_N * `SA_N;

  logic                     active;
  logic [$clog2(LANES)-1:0] lane;

  // First active lane at or after the scan point, and whether another follows
  logic [$clog2(LANES)-1:0] cur;
  logic                     found;
  logic                     more;
  logic                     emit;

  always_comb begin
    cur   = lane;
    found = 1'b0;
    more  = 1'b0;
    for (int n = 0; n < LANES; n++) begin
      if (n >= lane && pe_mask[n]) begin
        if (!found) begin
          cur   = ($clog2(LANES))'(n);
          found = 1'b1;
        end else begin
          more = 1'b1;
        end
      end
    end
  end

  assign emit = active && !hold && found;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active     <= 1'b0;
      lane       <= '0;
      drain_done <= 1'b0;
    end else begin
      drain_done <= 1'b0;
      if (drain_go) begin
        active <= 1'b1;
        lane   <= '0;
      end else if (active && !found) begin
        // Nothing left to send
        active     <= 1'b0;
        drain_done <= 1'b1;
      end else if (emit) begin
        if (more) begin
          lane <= cur + 1'b1;
        end else begin
          active     <= 1'b0;
          drain_done <= 1'b1;
        end
      end
    end
  end

  // Pixel out with absolute map coordinates
  assign out_valid = emit;
  assign out_layer = layer;
  assign out_chnl  = chnl;
  assign out_row   = tile_row + coord_t'(cur / `SA_N);
  assign out_col   = tile_col + coord_t'(cur % `SA_N);
  assign out_data  = acc[cur];

endmodule

`default_nettype wire

// ==== hdl/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module mac_array
  import conv_pkg::*;
(
  input  logic      clk
  ,input  logic     reset
  ,input  logic     clear
  ,input  logic     bias_valid
  ,input  logic     step_valid
  ,input  feat_t [`SA_N*`SA_N-1:0] feat_data
  ,input  wgt_t     wgt_data
  ,output acc_t  [`SA_N*`SA_N-1:0] acc
);

  localparam int LANES = `SA_N * `SA_N;

  // Per-lane product, weight broadcast to all lanes
  logic signed [15:0] prod [LANES];

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      prod[i] = $signed(feat_data[i]) * $signed(wgt_data);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < LANES; i++) begin
        acc[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LANES; i++) begin
        if (clear) begin
          acc[i] <= '0;
        end else if (bias_valid) begin
          // Same bias for every pixel of the channel
          acc[i] <= acc_t'($signed(wgt_data));
        end else if (step_valid) begin
          acc[i] <= acc[i] + acc_t'(prod[i]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch
  import conv_pkg::*;
(
  input  logic       clk
  ,input  logic      reset
  ,input  logic      run_go
  ,input  logic      bias_req
  ,input  logic      hold
  ,input  layer_idx_t layer
  ,input  chnl_idx_t chnl
  ,input  chnl_idx_t in_ch
  ,input  coord_t    tile_row
  ,input  coord_t    tile_col
  ,output logic      feat_req
  ,output logic      wgt_req
  ,output logic      wgt_bias
  ,output layer_idx_t req_layer
  ,output chnl_idx_t req_chnl
  ,output chnl_idx_t req_k
  ,output coord_t    req_row
  ,output coord_t    req_col
  ,output logic      bias_valid
  ,output logic      step_valid
  ,output logic      fetch_idle
);

  // Steps still to be issued for this tile
  logic      active;
  chnl_idx_t k;
  logic      issue;

  // No step goes out while hold is high
  assign issue = active && !hold;

  // Memory request strobes
  assign feat_req  = issue;
  assign wgt_req   = issue || bias_req;
  assign wgt_bias  = bias_req;
  assign req_k     = issue ? k : '0;
  assign req_layer = layer;
  assign req_chnl  = chnl;
  assign req_row   = tile_row;
  assign req_col   = tile_col;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active     <= 1'b0;
      k          <= '0;
      bias_valid <= 1'b0;
      step_valid <= 1'b0;
    end else begin
      // Valid flags trail the requests by the memory latency
      bias_valid <= bias_req;
      step_valid <= issue;
      if (run_go) begin
        active <= 1'b1;
        k      <= '0;
      end else if (issue) begin
        if (k == in_ch) active <= 1'b0;
        else            k <= k + 1'b1;
      end
    end
  end

  // Idle once the last returned step has been accumulated
  assign fetch_idle = !active && !step_valid;

endmodule

`default_nettype wire

// ==== hdl/layer_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module layer_sequencer
  import conv_pkg::*;
(
  input  logic       clk
  ,input  logic      reset
  ,input  logic      start
  ,input  logic      hold
  ,input  logic      fetch_idle
  ,input  logic      drain_done
  ,output logic      clear
  ,output logic      bias_req
  ,output logic      run_go
  ,output logic      drain_go
  ,output logic      busy
  ,output logic      done
  ,output layer_idx_t layer
  ,output chnl_idx_t chnl
  ,output coord_t    tile_row
  ,output coord_t    tile_col
  ,output chnl_idx_t in_ch
  ,output logic [15:0] pe_mask
);

  seq_state_t state, next_state;

  // Geometry of the current layer
  coord_t lay_h, lay_w;
  logic [$clog2(`MAX_CH):0] lay_in_c, lay_out_c;

  // Remaining extent from the tile origin, clipped to the array
  coord_t rem_h, rem_w;
  coord_t ext_h, ext_w;

  logic last_col, last_row, last_chnl, last_layer, last_all;

  // Table lookup on the layer index
  always_comb begin
    case (layer)
      2'd0: begin
        lay_h     = coord_t'(`L0_H);
        lay_w     = coord_t'(`L0_W);
        lay_in_c  = `L0_IN_C;
        lay_out_c = `L0_OUT_C;
      end
      2'd1: begin
        lay_h     = coord_t'(`L1_H);
        lay_w     = coord_t'(`L1_W);
        lay_in_c  = `L1_IN_C;
        lay_out_c = `L1_OUT_C;
      end
      default: begin
        lay_h     = coord_t'(`L2_H);
        lay_w     = coord_t'(`L2_W);
        lay_in_c  = `L2_IN_C;
        lay_out_c = `L2_OUT_C;
      end
    endcase
  end

  // Tile extent and active PE mask
  always_comb begin
    rem_h = lay_h - tile_row;
    rem_w = lay_w - tile_col;
    ext_h = (rem_h < coord_t'(`SA_N)) ? rem_h : coord_t'(`SA_N);
    ext_w = (rem_w < coord_t'(`SA_N)) ? rem_w : coord_t'(`SA_N);
    for (int i = 0; i < `SA_N; i++) begin
      for (int j = 0; j < `SA_N; j++) begin
        pe_mask[i*`SA_N+j] = (i < ext_h) && (j < ext_w);
      end
    end
  end

  // End conditions, tiles walk columns first
  assign last_col   = (tile_col + coord_t'(`SA_N)) >= lay_w;
  assign last_row   = (tile_row + coord_t'(`SA_N)) >= lay_h;
  assign last_chnl  = (chnl == chnl_idx_t'(lay_out_c - 1'b1));
  assign last_layer = (layer == layer_idx_t'(`NUM_LAYERS - 1));
  assign last_all   = last_col && last_row && last_chnl && last_layer;

  // Count minus one, as the fetch step counter expects
  assign in_ch = chnl_idx_t'(lay_in_c - 1'b1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= S_IDLE;
      layer    <= '0;
      chnl     <= '0;
      tile_row <= '0;
      tile_col <= '0;
    end else begin
      state <= next_state;
      if (state == S_IDLE && start) begin
        layer    <= '0;
        chnl     <= '0;
        tile_row <= '0;
        tile_col <= '0;
      end else if (state == S_DRAIN && drain_done) begin
        // Advance column, then row, then channel, then layer
        if (!last_col) begin
          tile_col <= tile_col + coord_t'(`SA_N);
        end else begin
          tile_col <= '0;
          if (!last_row) begin
            tile_row <= tile_row + coord_t'(`SA_N);
          end else begin
            tile_row <= '0;
            if (!last_chnl) begin
              chnl <= chnl + 1'b1;
            end else begin
              chnl  <= '0;
              // Wrap so a later start repeats the same walk
              layer <= last_layer ? '0 : layer + 1'b1;
            end
          end
        end
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:      if (start) next_state = S_CLEAR;
      S_CLEAR:     next_state = S_BIAS_REQ;
      // Bias read waits out hold like any other read
      S_BIAS_REQ:  if (!hold) next_state = S_BIAS_LOAD;
      S_BIAS_LOAD: next_state = S_RUN;
      S_RUN:       if (fetch_idle) next_state = S_DRAIN;
      S_DRAIN: begin
        if (drain_done) next_state = last_all ? S_DONE : S_CLEAR;
      end
      S_DONE:      next_state = S_IDLE;
      default:     next_state = S_IDLE;
    endcase
  end

  // Strobes to the datapath
  assign clear    = (state == S_CLEAR);
  assign bias_req = (state == S_BIAS_REQ) && !hold;
  assign run_go   = (state == S_BIAS_LOAD);
  assign drain_go = (state == S_RUN) && fetch_idle;
  assign busy     = (state != S_IDLE);
  assign done     = (state == S_DONE);

endmodule

`default_nettype wire

// ==== hdl/conv_pkg.sv ====
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

  // Feature and weight values
  typedef logic signed [7:0]  feat_t;
  typedef logic signed [7:0]  wgt_t;

  // Accumulator, wide enough for bias plus MAX_CH products
  typedef logic signed [23:0] acc_t;

  typedef logic [$clog2(`NUM_LAYERS)-1:0] layer_idx_t;

  // Shared by input step and output channel
  typedef logic [$clog2(`MAX_CH)-1:0]     chnl_idx_t;

  // Output map row or column, one spare bit for origin plus SA_N
  typedef logic [$clog2(`MAX_DIM):0]      coord_t;

  // Sequencer states
  typedef enum logic [2:0] {
    S_IDLE,
    S_CLEAR,
    S_BIAS_REQ,
    S_BIAS_LOAD,
    S_RUN,
    S_DRAIN,
    S_DONE
  } seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Side of the square MAC array
`define SA_N        4

// Number of layers in the fixed layer list
`define NUM_LAYERS  3

// Largest output height or width over all layers
`define MAX_DIM     8

// Largest input or output channel count
`define MAX_CH      4

// Layer 0, 6x6 output map
`define L0_H        6
`define L0_W        6
`define L0_IN_C     3
`define L0_OUT_C    2

// Layer 1, exactly one tile
`define L1_H        4
`define L1_W        4
`define L1_IN_C     4
`define L1_OUT_C    3

// Layer 2, wide and short so both edges get masked
`define L2_H        3
`define L2_W        5
`define L2_IN_C     2
`define L2_OUT_C    2

`endif
